// ==== hdl/rv_isa_pkg.sv ====
// RV64 encoding constants and opcode enums, imported by the decode stage modules
package rv_isa_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int GPR_NUM     = 32;

  typedef logic [GPR_ADDR_WD-1:0] gpr_addr_t;
  typedef logic [XLEN-1:0]        xlen_t;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  // funct3
  localparam logic [2:0] F3_ADDI    = 3'b000;
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_BLT     = 3'b100;

  // funct7
  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage

// ==== hdl/id_bus_pkg.sv ====
// pipeline bus structs and execute/branch operation enums shared by the decode stage
package id_bus_pkg;

  import rv_isa_pkg::*;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_PASS_IMM, // lui
    ALU_LINK      // pc + 4
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_JUMP
  } br_op_e;

  typedef struct packed {
    logic [INST_WD-1:0] inst;
    xlen_t              pc;
  } fs_to_ds_t;

  typedef struct packed {
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     imm;
    xlen_t     pc;
    alu_op_e   alu_op;
    logic      src2_is_imm;
    gpr_addr_t rd;
    logic      gpr_wen;
    logic      invalid;
  } ds_to_es_t;

  typedef struct packed {
    logic  taken;
    xlen_t target;
  } br_bus_t;

  typedef struct packed {
    logic      wen;
    gpr_addr_t waddr;
    xlen_t     wdata;
  } ws_to_rf_t;

  typedef struct packed {
    alu_op_e alu_op;
    br_op_e  br_op;
    logic    src2_is_imm;
    logic    gpr_wen;
    logic    invalid;
  } dec_ctrl_t;

endpackage

// ==== hdl/id_stage_reg.sv ====
// decode stage input register, holds the valid bit and the bus taken from fetch
module id_stage_reg
  import id_bus_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_fs_to_ds_valid,
  input  fs_to_ds_t i_fs_to_ds_bus,
  input  logic      i_ds_allowin,
  output logic      o_ds_valid,
  output fs_to_ds_t o_ds_bus
);

  logic ds_valid_q;
  fs_to_ds_t ds_bus_q;

  // valid follows fetch whenever we allow in, so an issue with no new input empties the stage
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid_q <= 1'b0;
    end else if (i_ds_allowin) begin
      ds_valid_q <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && i_ds_allowin) begin
      ds_bus_q <= i_fs_to_ds_bus; // transfer
    end
  end

  assign o_ds_valid = ds_valid_q;
  assign o_ds_bus   = ds_bus_q;

endmodule

// ==== hdl/id_decoder.sv ====
// combinational decoder for the supported RV64 subset, gives register fields, immediate, controls
module id_decoder
  import rv_isa_pkg::*;
  import id_bus_pkg::*;
(
  input  logic [INST_WD-1:0] i_inst,
  output gpr_addr_t          o_rs1,
  output gpr_addr_t          o_rs2,
  output gpr_addr_t          o_rd,
  output xlen_t              o_imm,
  output dec_ctrl_t          o_ctrl
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i, imm_u, imm_b, imm_j;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];
  assign o_rd  = i_inst[11:7];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    // anything not matched below stays invalid
    o_ctrl.alu_op      = ALU_ADD;
    o_ctrl.br_op       = BR_NONE;
    o_ctrl.src2_is_imm = 1'b0;
    o_ctrl.gpr_wen     = 1'b0;
    o_ctrl.invalid     = 1'b1;
    o_imm              = '0;
    case (opcode)
      OP_IMM: begin
        if (funct3 == F3_ADDI) begin
          o_ctrl.src2_is_imm = 1'b1;
          o_ctrl.gpr_wen     = 1'b1;
          o_ctrl.invalid     = 1'b0;
          o_imm              = imm_i;
        end
      end
      OP: begin
        if (funct3 == F3_ADD_SUB && (funct7 == F7_ADD || funct7 == F7_SUB)) begin
          o_ctrl.alu_op  = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          o_ctrl.gpr_wen = 1'b1;
          o_ctrl.invalid = 1'b0;
        end
      end
      LUI: begin
        o_ctrl.alu_op      = ALU_PASS_IMM;
        o_ctrl.src2_is_imm = 1'b1;
        o_ctrl.gpr_wen     = 1'b1;
        o_ctrl.invalid     = 1'b0;
        o_imm              = imm_u;
      end
      BRANCH: begin
        o_imm = imm_b;
        case (funct3)
          F3_BEQ:  o_ctrl.br_op = BR_EQ;
          F3_BNE:  o_ctrl.br_op = BR_NE;
          F3_BLT:  o_ctrl.br_op = BR_LT;
          default: o_ctrl.br_op = BR_NONE;
        endcase
        o_ctrl.invalid = (o_ctrl.br_op == BR_NONE);
      end
      JAL: begin
        o_ctrl.alu_op  = ALU_LINK; // rd gets pc + 4
        o_ctrl.br_op   = BR_JUMP;
        o_ctrl.gpr_wen = 1'b1;
        o_ctrl.invalid = 1'b0;
        o_imm          = imm_j;
      end
      default: ;
    endcase
  end

endmodule

// ==== hdl/id_gpr_file.sv ====
// general register file, two combinational reads and one write from write-back
module id_gpr_file
  import rv_isa_pkg::*;
  import id_bus_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  gpr_addr_t i_raddr1,
  input  gpr_addr_t i_raddr2,
  output xlen_t     o_rdata1,
  output xlen_t     o_rdata2,
  input  ws_to_rf_t i_wb
);

  xlen_t gpr_q [1:GPR_NUM-1]; // x0 not stored

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < GPR_NUM; i++) begin
        gpr_q[i] <= '0;
      end
    end else if (i_wb.wen && i_wb.waddr != '0) begin
      gpr_q[i_wb.waddr] <= i_wb.wdata;
    end
  end

  // x0 reads zero
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : gpr_q[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : gpr_q[i_raddr2];

endmodule

// ==== hdl/id_branch_unit.sv ====
// branch condition and target for the decoded branch or jump
module id_branch_unit
  import rv_isa_pkg::*;
  import id_bus_pkg::*;
(
  input  br_op_e i_br_op,
  input  xlen_t  i_rs1data,
  input  xlen_t  i_rs2data,
  input  xlen_t  i_pc,
  input  xlen_t  i_imm,
  output logic   o_br_cond,
  output xlen_t  o_br_target
);

  always_comb begin
    case (i_br_op)
      BR_EQ:   o_br_cond = (i_rs1data == i_rs2data);
      BR_NE:   o_br_cond = (i_rs1data != i_rs2data);
      BR_LT:   o_br_cond = ($signed(i_rs1data) < $signed(i_rs2data));
      BR_JUMP: o_br_cond = 1'b1;
      default: o_br_cond = 1'b0;
    endcase
  end

  assign o_br_target = i_pc + i_imm; // same adder for b and j types

endmodule

// ==== hdl/id_issue_ctrl.sv ====
// issue side of decode: RAW stall, allowin, issue valid and the redirect to fetch
module id_issue_ctrl
  import rv_isa_pkg::*;
  import id_bus_pkg::*;
(
  input  logic      i_ds_valid,
  input  logic      i_es_allowin,
  input  gpr_addr_t i_rs1,
  input  gpr_addr_t i_rs2,
  input  gpr_addr_t i_es_rd,
  input  gpr_addr_t i_ms_rd,
  input  gpr_addr_t i_ws_rd,
  input  logic      i_br_cond,
  input  xlen_t     i_br_target,
  output logic      o_ds_allowin,
  output logic      o_ds_to_es_valid,
  output br_bus_t   o_br_bus
);

  logic ds_ready_go;

  // pending write to one of our sources, rd 0 means none
  function automatic logic raw_hit(gpr_addr_t rd, gpr_addr_t rs1, gpr_addr_t rs2);
    return (rd != '0) && (rd == rs1 || rd == rs2);
  endfunction

  assign ds_ready_go = !(raw_hit(i_es_rd, i_rs1, i_rs2)
                      || raw_hit(i_ms_rd, i_rs1, i_rs2)
                      || raw_hit(i_ws_rd, i_rs1, i_rs2));

  assign o_ds_allowin     = !i_ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = i_ds_valid && ds_ready_go;

  // redirect only in the issue cycle
  assign o_br_bus.taken  = o_ds_to_es_valid && i_es_allowin && i_br_cond;
  assign o_br_bus.target = i_br_target;

endmodule

// ==== hdl/id_stage.sv ====
// instruction decode stage top, takes fetch bus, issues to execute and redirects fetch
module id_stage
  import rv_isa_pkg::*;
  import id_bus_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_fs_to_ds_valid,
  input  fs_to_ds_t i_fs_to_ds_bus,
  output logic      o_ds_allowin,
  output logic      o_ds_to_es_valid,
  output ds_to_es_t o_ds_to_es_bus,
  input  logic      i_es_allowin,
  output br_bus_t   o_br_bus,
  input  ws_to_rf_t i_ws_to_rf_bus,
  input  gpr_addr_t i_es_rd,
  input  gpr_addr_t i_ms_rd,
  input  gpr_addr_t i_ws_rd
);

  logic      ds_valid;
  fs_to_ds_t ds_bus;
  gpr_addr_t rs1, rs2, rd;
  xlen_t     imm, rs1_data, rs2_data, br_target;
  dec_ctrl_t ctrl;
  logic      br_cond;

  id_stage_reg u_stage_reg (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_to_ds_bus   (i_fs_to_ds_bus),
    .i_ds_allowin     (o_ds_allowin),
    .o_ds_valid       (ds_valid),
    .o_ds_bus         (ds_bus)
  );

  id_decoder u_decoder (
    .i_inst (ds_bus.inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (rd),
    .o_imm  (imm),
    .o_ctrl (ctrl)
  );

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data),
    .i_wb     (i_ws_to_rf_bus)
  );

  id_branch_unit u_branch_unit (
    .i_br_op     (ctrl.br_op),
    .i_rs1data   (rs1_data),
    .i_rs2data   (rs2_data),
    .i_pc        (ds_bus.pc),
    .i_imm       (imm),
    .o_br_cond   (br_cond),
    .o_br_target (br_target)
  );

  id_issue_ctrl u_issue_ctrl (
    .i_ds_valid       (ds_valid),
    .i_es_allowin     (i_es_allowin),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .i_es_rd          (i_es_rd),
    .i_ms_rd          (i_ms_rd),
    .i_ws_rd          (i_ws_rd),
    .i_br_cond        (br_cond),
    .i_br_target      (br_target),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_br_bus         (o_br_bus)
  );

  always_comb begin
    o_ds_to_es_bus.rs1_data    = rs1_data;
    o_ds_to_es_bus.rs2_data    = rs2_data;
    o_ds_to_es_bus.imm         = imm;
    o_ds_to_es_bus.pc          = ds_bus.pc;
    o_ds_to_es_bus.alu_op      = ctrl.alu_op;
    o_ds_to_es_bus.src2_is_imm = ctrl.src2_is_imm;
    o_ds_to_es_bus.rd          = rd;
    o_ds_to_es_bus.gpr_wen     = ctrl.gpr_wen;
    o_ds_to_es_bus.invalid     = ctrl.invalid;
  end

endmodule

// ==== bench/id_stage_chk.sv ====
// handshake assertions for the decode stage bound into every id_stage instance
module id_stage_chk
  import id_bus_pkg::*;
(
  input logic      i_clk,
  input logic      i_rst_n,
  input logic      i_ds_valid,
  input logic      i_ds_allowin,
  input logic      i_ds_to_es_valid,
  input ds_to_es_t i_ds_to_es_bus,
  input logic      i_es_allowin,
  input logic      i_br_taken
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;

  a_allowin_when_empty: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) !i_ds_valid |-> i_ds_allowin
  ) else begin
    $error("stage is empty but allowin is low");
    fail_cnt++;
  end

  // back-pressure holds the outgoing bus
  a_bus_held: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_ds_to_es_valid && !i_es_allowin) |=> $stable(i_ds_to_es_bus)
  ) else begin
    $error("outgoing bus changed while execute held it off");
    fail_cnt++;
  end

  a_taken_on_issue: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_br_taken |-> (i_ds_to_es_valid && i_es_allowin)
  ) else begin
    $error("redirect taken outside an issue cycle");
    fail_cnt++;
  end

endmodule

bind id_stage id_stage_chk u_chk (
  .i_clk            (i_clk),
  .i_rst_n          (i_rst_n),
  .i_ds_valid       (ds_valid),
  .i_ds_allowin     (o_ds_allowin),
  .i_ds_to_es_valid (o_ds_to_es_valid),
  .i_ds_to_es_bus   (o_ds_to_es_bus),
  .i_es_allowin     (i_es_allowin),
  .i_br_taken       (o_br_bus.taken)
);

// ==== bench/tb_id_stage.sv ====
// testbench for the decode stage that feeds fetch and checks every issue against a reference decode
module tb_id_stage
  import rv_isa_pkg::*;
  import id_bus_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_TESTS     = 29;
  localparam int CYCLE_LIMIT = 40 * N_TESTS + 200;
  localparam int BUS_WD      = $bits(ds_to_es_t);

  logic      i_clk;
  logic      i_rst_n;
  logic      i_fs_to_ds_valid;
  fs_to_ds_t i_fs_to_ds_bus;
  logic      o_ds_allowin;
  logic      o_ds_to_es_valid;
  ds_to_es_t o_ds_to_es_bus;
  logic      i_es_allowin;
  br_bus_t   o_br_bus;
  ws_to_rf_t i_ws_to_rf_bus;
  gpr_addr_t i_es_rd;
  gpr_addr_t i_ms_rd;
  gpr_addr_t i_ws_rd;

  logic [31:0][63:0] ref_rf; // shadow of the register file
  fs_to_ds_t sent_q[$];
  fs_to_ds_t cur;
  ds_to_es_t got;
  ds_to_es_t want;
  br_bus_t   want_br;
  ds_to_es_t held_bus;
  xlen_t     pc = 64'h8000_0000;
  int seed   = 47071;
  int errors = 0;
  int sent   = 0;
  int issued = 0;
  int cycles = 0;

  id_stage i_id_stage (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, instructions stopped issuing", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [BUS_WD-1:0] g,
                                 input logic [BUS_WD-1:0] w);
    $display("error %s: got %0h expected %0h", name, g, w);
    errors++;
  endtask

  function automatic logic [31:0] enc_i(logic [11:0] imm, gpr_addr_t rs1, logic [2:0] f3,
                                        gpr_addr_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, gpr_addr_t rs2, gpr_addr_t rs1,
                                        logic [2:0] f3, gpr_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, gpr_addr_t rs2, gpr_addr_t rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, gpr_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // expected execute bus and redirect from the instruction set rules
  function automatic void ref_decode(input logic [31:0] inst, input xlen_t pc_in,
                                     input logic [31:0][63:0] rf,
                                     output ds_to_es_t ds, output br_bus_t br);
    logic [2:0] f3;
    logic [6:0] f7;
    xlen_t      a;
    xlen_t      b;
    f3 = inst[14:12];
    f7 = inst[31:25];
    a  = rf[inst[19:15]];
    b  = rf[inst[24:20]];
    ds = '0;
    br = '0;
    ds.rs1_data = a;
    ds.rs2_data = b;
    ds.pc       = pc_in;
    ds.rd       = inst[11:7];
    ds.alu_op   = ALU_ADD;
    ds.invalid  = 1'b1;
    case (inst[6:0])
      7'b0010011: begin
        if (f3 == 3'b000) begin // addi
          ds.imm         = {{52{inst[31]}}, inst[31:20]};
          ds.src2_is_imm = 1'b1;
          ds.gpr_wen     = 1'b1;
          ds.invalid     = 1'b0;
        end
      end
      7'b0110011: begin
        if (f3 == 3'b000 && (f7 == 7'h00 || f7 == 7'h20)) begin
          ds.alu_op  = f7[5] ? ALU_SUB : ALU_ADD;
          ds.gpr_wen = 1'b1;
          ds.invalid = 1'b0;
        end
      end
      7'b0110111: begin
        ds.imm         = {{32{inst[31]}}, inst[31:12], 12'h000};
        ds.alu_op      = ALU_PASS_IMM;
        ds.src2_is_imm = 1'b1;
        ds.gpr_wen     = 1'b1;
        ds.invalid     = 1'b0;
      end
      7'b1100011: begin
        ds.imm     = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        br.target  = pc_in + ds.imm;
        ds.invalid = !(f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b100);
        case (f3)
          3'b000:  br.taken = (a == b);
          3'b001:  br.taken = (a != b);
          3'b100:  br.taken = ($signed(a) < $signed(b));
          default: br.taken = 1'b0;
        endcase
      end
      7'b1101111: begin
        ds.imm     = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        ds.alu_op  = ALU_LINK;
        ds.gpr_wen = 1'b1;
        ds.invalid = 1'b0;
        br.target  = pc_in + ds.imm;
        br.taken   = 1'b1;
      end
      default: ;
    endcase
  endfunction

  always @(negedge i_clk) begin
    if (i_rst_n && o_ds_to_es_valid && i_es_allowin) begin
      issued++;
      if (sent_q.size() == 0) begin
        $display("an instruction issued with none waiting in the stage");
        errors++;
      end else begin
        cur = sent_q.pop_front();
        got = o_ds_to_es_bus;
        ref_decode(cur.inst, cur.pc, ref_rf, want, want_br);
        if (got.rs1_data !== want.rs1_data) begin
          report_mismatch("rs1_data", got.rs1_data, want.rs1_data);
        end
        if (got.rs2_data !== want.rs2_data) begin
          report_mismatch("rs2_data", got.rs2_data, want.rs2_data);
        end
        if (got.pc !== want.pc) report_mismatch("pc", got.pc, want.pc);
        if (got.rd !== want.rd) report_mismatch("rd", got.rd, want.rd);
        if (got.gpr_wen !== want.gpr_wen) begin
          report_mismatch("gpr_wen", got.gpr_wen, want.gpr_wen);
        end
        if (got.invalid !== want.invalid) begin
          report_mismatch("invalid", got.invalid, want.invalid);
        end
        if (o_br_bus.taken !== want_br.taken) begin
          report_mismatch("taken", o_br_bus.taken, want_br.taken);
        end
        if (!want.invalid && got.imm !== want.imm) report_mismatch("imm", got.imm, want.imm);
        if (!want.invalid && got.alu_op !== want.alu_op) begin
          report_mismatch("alu_op", got.alu_op, want.alu_op);
        end
        if (!want.invalid && got.src2_is_imm !== want.src2_is_imm) begin
          report_mismatch("src2_is_imm", got.src2_is_imm, want.src2_is_imm);
        end
        if (want_br.taken && o_br_bus.target !== want_br.target) begin
          report_mismatch("target", o_br_bus.target, want_br.target);
        end
      end
    end
  end

  task automatic write_gpr(input gpr_addr_t addr, input xlen_t data);
    i_ws_to_rf_bus.wen   = 1'b1;
    i_ws_to_rf_bus.waddr = addr;
    i_ws_to_rf_bus.wdata = data;
    if (addr != '0) ref_rf[addr] = data; // x0 keeps zero
    @(posedge i_clk);
    #1;
  endtask

  // holds fetch valid until the stage takes the instruction
  task automatic send_inst(input logic [31:0] inst);
    logic done;
    done = 1'b0;
    i_fs_to_ds_valid    = 1'b1;
    i_fs_to_ds_bus.inst = inst;
    i_fs_to_ds_bus.pc   = pc;
    sent_q.push_back(i_fs_to_ds_bus);
    sent++;
    while (!done) begin
      @(negedge i_clk);
      done = o_ds_allowin;
      @(posedge i_clk);
      #1;
    end
    i_fs_to_ds_valid = 1'b0;
    pc = pc + 4;
  endtask

  task automatic drain();
    while (issued != sent) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  // stall on one pending destination, then clear it
  task automatic check_stall(input int stage);
    drain();
    case (stage)
      0:       i_es_rd = 5'd21;
      1:       i_ms_rd = 5'd22;
      default: i_ws_rd = 5'd21;
    endcase
    send_inst(enc_r(7'h00, 5'd22, 5'd21, 3'b000, 5'd20));
    repeat (4) begin
      @(negedge i_clk);
      if (o_ds_to_es_valid !== 1'b0) report_mismatch("o_ds_to_es_valid", o_ds_to_es_valid, 0);
      if (o_ds_allowin !== 1'b0) report_mismatch("o_ds_allowin", o_ds_allowin, 0);
    end
    @(posedge i_clk);
    #1;
    i_es_rd = '0;
    i_ms_rd = '0;
    i_ws_rd = '0;
    drain();
  endtask

  initial begin
    logic [12:0] bimm;
    gpr_addr_t   ra;
    gpr_addr_t   rb;
    i_rst_n          = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_to_ds_bus   = '0;
    i_es_allowin     = 1'b1;
    i_ws_to_rf_bus   = '0;
    i_es_rd          = '0;
    i_ms_rd          = '0;
    i_ws_rd          = '0;
    ref_rf           = '0;
    repeat (8) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    @(negedge i_clk);
    if (o_ds_to_es_valid !== 1'b0) report_mismatch("o_ds_to_es_valid", o_ds_to_es_valid, 0);
    if (o_ds_allowin !== 1'b1) report_mismatch("o_ds_allowin", o_ds_allowin, 1);
    @(posedge i_clk);
    #1;
    for (int r = 0; r < GPR_NUM; r++) write_gpr(gpr_addr_t'(r), {$random(seed), $random(seed)});
    i_ws_to_rf_bus.wen = 1'b0;

    send_inst(enc_i(12'($random(seed)), 5'd1, 3'b000, 5'd3, 7'b0010011));
    send_inst(enc_i(12'hfff, 5'd0, 3'b000, 5'd4, 7'b0010011)); // addi x4, x0, -1
    send_inst(enc_r(7'h00, 5'd7, 5'd0, 3'b000, 5'd5));
    send_inst(enc_r(7'h00, 5'd10, 5'd9, 3'b000, 5'd8));
    send_inst(enc_r(7'h20, 5'd0, 5'd12, 3'b000, 5'd11)); // sub with rs2 = x0
    send_inst({20'($random(seed)), 5'd13, 7'b0110111});

    for (int i = 0; i < 12; i++) begin
      bimm    = 13'($random(seed));
      bimm[0] = 1'b0;
      ra      = gpr_addr_t'($random(seed));
      rb      = gpr_addr_t'($random(seed));
      send_inst(enc_b(bimm, rb, ra, (i % 3 == 0) ? 3'b000 : (i % 3 == 1) ? 3'b001 : 3'b100));
    end
    send_inst(enc_b(13'h0040, 5'd14, 5'd14, 3'b000)); // always taken
    send_inst(enc_b(13'h0040, 5'd14, 5'd14, 3'b001)); // never taken
    send_inst(enc_j(21'h00_0800, 5'd1));
    send_inst(enc_j(21'h1f_fff0, 5'd0));

    check_stall(0);
    check_stall(1);
    check_stall(2);

    // execute refuses the instruction for a while
    drain();
    i_es_allowin = 1'b0;
    send_inst(enc_i(12'h123, 5'd15, 3'b000, 5'd16, 7'b0010011));
    @(negedge i_clk);
    held_bus = o_ds_to_es_bus;
    repeat (5) begin
      if (o_ds_to_es_valid !== 1'b1) report_mismatch("o_ds_to_es_valid", o_ds_to_es_valid, 1);
      if (o_ds_allowin !== 1'b0) report_mismatch("o_ds_allowin", o_ds_allowin, 0);
      if (o_ds_to_es_bus !== held_bus) report_mismatch("o_ds_to_es_bus", o_ds_to_es_bus, held_bus);
      @(negedge i_clk);
    end
    @(posedge i_clk);
    #1;
    i_es_allowin = 1'b1;
    drain();

    send_inst(enc_i(12'h010, 5'd2, 3'b011, 5'd17, 7'b0000011)); // load is not decoded
    send_inst(enc_r(7'h01, 5'd3, 5'd2, 3'b000, 5'd18));
    send_inst(enc_b(13'h0008, 5'd3, 5'd3, 3'b010)); // reserved branch funct3
    drain();
    repeat (4) @(posedge i_clk);

    if (issued != sent) begin
      $display("sent %0d instructions but %0d issued", sent, issued);
      errors++;
    end
    errors += i_id_stage.u_chk.fail_cnt;
    $display("errors %0d (assertions %0d), sent %0d, issued %0d",
             errors, i_id_stage.u_chk.fail_cnt, sent, issued);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== all.f ====
hdl/rv_isa_pkg.sv
hdl/id_bus_pkg.sv
hdl/id_stage_reg.sv
hdl/id_decoder.sv
hdl/id_gpr_file.sv
hdl/id_branch_unit.sv
hdl/id_issue_ctrl.sv
hdl/id_stage.sv
bench/id_stage_chk.sv
bench/tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - target: rtl
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/id_bus_pkg.sv
      - hdl/id_stage_reg.sv
      - hdl/id_decoder.sv
      - hdl/id_gpr_file.sv
      - hdl/id_branch_unit.sv
      - hdl/id_issue_ctrl.sv
      - hdl/id_stage.sv
  - target: test
    files:
      - bench/id_stage_chk.sv
      - bench/tb_id_stage.sv
